/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_reorder_buffer
FILELIST ?= project.f
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o V$(TOP)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* hw/reorder_buffer.sv */
`timescale 1ns/10ps

module reorder_buffer
	import rob_pkg::*;
(
	input  logic                                    clock,
	input  logic                                    arst_n,
	input  logic [rob_width-1:0]                    dispatch_en,
	input  logic [rob_width-1:0][areg_bits-1:0]     dest_reg,
	input  logic [rob_width-1:0][preg_bits-1:0]     new_tag,
	input  logic [rob_width-1:0][preg_bits-1:0]     old_tag,
	input  logic [rob_width-1:0]                    cdb_valid,
	input  logic [rob_width-1:0][preg_bits-1:0]     cdb_tag,
	input  logic                                    br_valid,
	input  logic [preg_bits-1:0]                    br_tag,
	input  logic                                    br_mispredict,
	input  logic [xlen-1:0]                         br_target,
	output logic [rob_width-1:0]                    dispatch_ready,
	output logic [rob_width-1:0][rob_idx_bits-1:0]  rob_idx,
	output logic [rob_width-1:0]                    retire_valid,
	output logic [rob_width-1:0][areg_bits-1:0]     retire_reg,
	output logic [rob_width-1:0][preg_bits-1:0]     retire_tag,
	output logic [rob_width-1:0][preg_bits-1:0]     retire_old_tag,
	output logic                                    rollback_en,
	output logic [xlen-1:0]                         rollback_pc
);

	logic [rob_width-1:0][rob_idx_bits-1:0] alloc_idx;
	logic [rob_width-1:0]                   alloc_we;
	logic [rob_idx_bits-1:0]                head_ptr;
	logic [1:0]                             retire_count;
	rob_state_t [rob_width-1:0]             head_state;
	logic [rob_width-1:0][areg_bits-1:0]    head_reg;
	logic [rob_width-1:0][preg_bits-1:0]    head_tag;
	logic [rob_width-1:0][preg_bits-1:0]    head_old_tag;
	logic [xlen-1:0]                        head_target;

	rob_alloc u_alloc (
		.clock          (clock),
		.arst_n         (arst_n),
		.dispatch_en    (dispatch_en),
		.retire_count   (retire_count),
		.rollback_en    (rollback_en),
		.head_ptr       (head_ptr),
		.dispatch_ready (dispatch_ready),
		.alloc_idx      (alloc_idx),
		.alloc_we       (alloc_we),
		.rob_idx        (rob_idx)
	);

	rob_retire u_retire (
		.clock          (clock),
		.arst_n         (arst_n),
		.head_state     (head_state),
		.head_reg       (head_reg),
		.head_tag       (head_tag),
		.head_old_tag   (head_old_tag),
		.head_target    (head_target),
		.head_ptr       (head_ptr),
		.retire_count   (retire_count),
		.retire_valid   (retire_valid),
		.retire_reg     (retire_reg),
		.retire_tag     (retire_tag),
		.retire_old_tag (retire_old_tag),
		.rollback_en    (rollback_en),
		.rollback_pc    (rollback_pc)
	);

	rob_entry_array u_entries (
		.clock         (clock),
		.arst_n        (arst_n),
		.alloc_idx     (alloc_idx),
		.alloc_we      (alloc_we),
		.dest_reg      (dest_reg),
		.new_tag       (new_tag),
		.old_tag       (old_tag),
		.cdb_valid     (cdb_valid),
		.cdb_tag       (cdb_tag),
		.br_valid      (br_valid),
		.br_tag        (br_tag),
		.br_mispredict (br_mispredict),
		.br_target     (br_target),
		.head_ptr      (head_ptr),
		.retire_count  (retire_count),
		.rollback_en   (rollback_en),
		.head_state    (head_state),
		.head_reg      (head_reg),
		.head_tag      (head_tag),
		.head_old_tag  (head_old_tag),
		.head_target   (head_target)
	);

endmodule

/* hw/rob_alloc.sv */
`timescale 1ns/10ps

module rob_alloc
	import rob_pkg::*;
(
	input  logic                                    clock,
	input  logic                                    arst_n,
	input  logic [rob_width-1:0]                    dispatch_en,
	input  logic [1:0]                              retire_count,
	input  logic                                    rollback_en,
	input  logic [rob_idx_bits-1:0]                 head_ptr,
	output logic [rob_width-1:0]                    dispatch_ready,
	output logic [rob_width-1:0][rob_idx_bits-1:0]  alloc_idx,
	output logic [rob_width-1:0]                    alloc_we,
	output logic [rob_width-1:0][rob_idx_bits-1:0]  rob_idx
);

	logic [rob_idx_bits-1:0] tail_q;
	logic [rob_idx_bits:0]   count_q;
	logic [rob_idx_bits:0]   n_alloc;
	logic [rob_idx_bits:0]   n_retire;

	// free slots taken from the count at the start of the cycle
	always_comb begin
		if (count_q <= (rob_idx_bits+1)'(rob_size - 2)) begin
			dispatch_ready = 2'b11;
		end
		else if (count_q == (rob_idx_bits+1)'(rob_size - 1)) begin
			dispatch_ready = 2'b01;
		end
		else begin
			dispatch_ready = 2'b00;
		end
	end

	// lane 1 always lands right after lane 0
	assign rob_idx[0] = tail_q;
	assign rob_idx[1] = tail_q + rob_idx_bits'(1);
	assign alloc_idx = rob_idx;

	// lane 1 is only taken together with lane 0
	assign alloc_we[0] = dispatch_en[0] & dispatch_ready[0] & ~rollback_en;
	assign alloc_we[1] = dispatch_en[1] & dispatch_en[0] & dispatch_ready[1] & ~rollback_en;

	assign n_alloc = alloc_we[0] + alloc_we[1];
	assign n_retire = {{(rob_idx_bits-1){1'b0}}, retire_count};

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			tail_q <= '0;
			count_q <= '0;
		end
		else if (rollback_en) begin
			// everything behind the branch is gone
			tail_q <= head_ptr + rob_idx_bits'(1);
			count_q <= '0;
		end
		else begin
			tail_q <= tail_q + n_alloc[rob_idx_bits-1:0];
			count_q <= count_q + n_alloc - n_retire;
		end
	end

endmodule

/* hw/rob_entry_array.sv */
`timescale 1ns/10ps

module rob_entry_array
	import rob_pkg::*;
(
	input  logic                                    clock,
	input  logic                                    arst_n,
	input  logic [rob_width-1:0][rob_idx_bits-1:0]  alloc_idx,
	input  logic [rob_width-1:0]                    alloc_we,
	input  logic [rob_width-1:0][areg_bits-1:0]     dest_reg,
	input  logic [rob_width-1:0][preg_bits-1:0]     new_tag,
	input  logic [rob_width-1:0][preg_bits-1:0]     old_tag,
	input  logic [rob_width-1:0]                    cdb_valid,
	input  logic [rob_width-1:0][preg_bits-1:0]     cdb_tag,
	input  logic                                    br_valid,
	input  logic [preg_bits-1:0]                    br_tag,
	input  logic                                    br_mispredict,
	input  logic [xlen-1:0]                         br_target,
	input  logic [rob_idx_bits-1:0]                 head_ptr,
	input  logic [1:0]                              retire_count,
	input  logic                                    rollback_en,
	output rob_state_t [rob_width-1:0]              head_state,
	output logic [rob_width-1:0][areg_bits-1:0]     head_reg,
	output logic [rob_width-1:0][preg_bits-1:0]     head_tag,
	output logic [rob_width-1:0][preg_bits-1:0]     head_old_tag,
	output logic [xlen-1:0]                         head_target
);

	rob_state_t             state_q  [rob_size];
	logic [areg_bits-1:0]   reg_q    [rob_size];
	logic [preg_bits-1:0]   tag_q    [rob_size];
	logic [preg_bits-1:0]   old_q    [rob_size];
	logic [xlen-1:0]        target_q [rob_size];

	logic [rob_width-1:0][rob_idx_bits-1:0] head_idx;

	assign head_idx[0] = head_ptr;
	assign head_idx[1] = head_ptr + rob_idx_bits'(1);

	always_comb begin
		for (int i = 0; i < rob_width; i++) begin
			head_state[i] = state_q[head_idx[i]];
			head_reg[i] = reg_q[head_idx[i]];
			head_tag[i] = tag_q[head_idx[i]];
			head_old_tag[i] = old_q[head_idx[i]];
		end
		head_target = target_q[head_idx[0]];
	end

	// later assignments win: completion, branch, retire clear, then dispatch
	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			for (int e = 0; e < rob_size; e++) begin
				state_q[e] <= rob_empty;
			end
		end
		else if (rollback_en) begin
			for (int e = 0; e < rob_size; e++) begin
				state_q[e] <= rob_empty;
			end
		end
		else begin
			for (int e = 0; e < rob_size; e++) begin
				for (int l = 0; l < rob_width; l++) begin
					if (cdb_valid[l] && cdb_tag[l] == tag_q[e] && state_q[e] == rob_wait) begin
						state_q[e] <= rob_done;
					end
				end
				// a late mispredict overrides an earlier done
				if (br_valid && br_tag == tag_q[e] && state_q[e] != rob_empty) begin
					state_q[e] <= br_mispredict ? rob_mispred : rob_done;
				end
			end
			for (int i = 0; i < rob_width; i++) begin
				if (i < retire_count) begin
					state_q[head_idx[i]] <= rob_empty;
				end
			end
			for (int l = 0; l < rob_width; l++) begin
				if (alloc_we[l]) begin
					state_q[alloc_idx[l]] <= rob_wait;
				end
			end
		end
	end

	// payload
	always_ff @(posedge clock) begin
		for (int e = 0; e < rob_size; e++) begin
			if (br_valid && br_tag == tag_q[e] && state_q[e] != rob_empty) begin
				target_q[e] <= br_target;
			end
		end
		for (int l = 0; l < rob_width; l++) begin
			if (alloc_we[l]) begin
				reg_q[alloc_idx[l]] <= dest_reg[l];
				tag_q[alloc_idx[l]] <= new_tag[l];
				old_q[alloc_idx[l]] <= old_tag[l];
			end
		end
	end

endmodule

/* hw/rob_pkg.sv */
package rob_pkg;

	// buffer geometry
	localparam int rob_size = 32;
	localparam int rob_width = 2;
	localparam int rob_idx_bits = 5;

	// register and tag widths
	localparam int areg_bits = 5;
	localparam int preg_bits = 6;

	localparam int xlen = 32;

	// per-entry state
	// rob_mispred marks a completed branch whose prediction was wrong
	typedef enum logic [1:0] {
		rob_empty   = 2'b00,
		rob_wait    = 2'b01,
		rob_done    = 2'b10,
		rob_mispred = 2'b11
	} rob_state_t;

endpackage

/* hw/rob_retire.sv */
`timescale 1ns/10ps

module rob_retire
	import rob_pkg::*;
(
	input  logic                                 clock,
	input  logic                                 arst_n,
	input  rob_state_t [rob_width-1:0]           head_state,
	input  logic [rob_width-1:0][areg_bits-1:0]  head_reg,
	input  logic [rob_width-1:0][preg_bits-1:0]  head_tag,
	input  logic [rob_width-1:0][preg_bits-1:0]  head_old_tag,
	input  logic [xlen-1:0]                      head_target,
	output logic [rob_idx_bits-1:0]              head_ptr,
	output logic [1:0]                           retire_count,
	output logic [rob_width-1:0]                 retire_valid,
	output logic [rob_width-1:0][areg_bits-1:0]  retire_reg,
	output logic [rob_width-1:0][preg_bits-1:0]  retire_tag,
	output logic [rob_width-1:0][preg_bits-1:0]  retire_old_tag,
	output logic                                 rollback_en,
	output logic [xlen-1:0]                      rollback_pc
);

	logic [rob_idx_bits-1:0] head_q;
	logic                    head_complete;
	logic                    head_mispred;
	logic                    next_done;

	assign head_complete = (head_state[0] == rob_done) || (head_state[0] == rob_mispred);
	assign head_mispred = (head_state[0] == rob_mispred);
	assign next_done = (head_state[1] == rob_done);

	// slot 1 never carries a mispredicted branch
	always_comb begin
		retire_valid[0] = head_complete;
		retire_valid[1] = head_complete & ~head_mispred & next_done;
	end

	assign retire_count = {1'b0, retire_valid[0]} + {1'b0, retire_valid[1]};

	// the branch itself still retires, then everything younger is dropped
	assign rollback_en = head_complete & head_mispred;
	assign rollback_pc = head_target;

	assign retire_reg = head_reg;
	assign retire_tag = head_tag;
	assign retire_old_tag = head_old_tag;

	assign head_ptr = head_q;

	always_ff @(posedge clock or negedge arst_n) begin
		if (!arst_n) begin
			head_q <= '0;
		end
		else begin
			head_q <= head_q + {{(rob_idx_bits-2){1'b0}}, retire_count};
		end
	end

endmodule

/* project.f */
hw/rob_pkg.sv
hw/rob_alloc.sv
hw/rob_retire.sv
hw/rob_entry_array.sv
hw/reorder_buffer.sv
test/reorder_buffer_props.sv
test/tb_reorder_buffer.sv

/* test/reorder_buffer_props.sv */
`timescale 1ns/10ps

module reorder_buffer_props
	import rob_pkg::*;
(
	input logic                 clock,
	input logic                 arst_n,
	input logic [rob_width-1:0] dispatch_ready,
	input logic [rob_width-1:0] retire_valid,
	input logic                 rollback_en
);

	// quiet outputs during and right after reset
	a_reset_quiet: assert property (@(posedge clock)
		!arst_n |-> (retire_valid == 2'b00 && !rollback_en && dispatch_ready == 2'b11))
		else $error("outputs not idle during reset");

	a_reset_release: assert property (@(posedge clock)
		$rose(arst_n) |-> (retire_valid == 2'b00 && !rollback_en && dispatch_ready == 2'b11))
		else $error("outputs not idle right after reset");

	// the mispredicted branch retires alone in slot 0
	a_rollback_slot0: assert property (@(posedge clock) disable iff (!arst_n)
		rollback_en |-> retire_valid == 2'b01)
		else $error("rollback without a lone slot 0 retire");

	a_retire_order: assert property (@(posedge clock) disable iff (!arst_n)
		retire_valid[1] |-> retire_valid[0])
		else $error("slot 1 retired without slot 0");

	// a rollback leaves the buffer empty
	a_rollback_empty: assert property (@(posedge clock) disable iff (!arst_n)
		rollback_en |=> (retire_valid == 2'b00 && !rollback_en && dispatch_ready == 2'b11))
		else $error("buffer not empty after rollback");

endmodule

bind reorder_buffer reorder_buffer_props u_props (
	.clock          (clock),
	.arst_n         (arst_n),
	.dispatch_ready (dispatch_ready),
	.retire_valid   (retire_valid),
	.rollback_en    (rollback_en)
);

/* test/tb_reorder_buffer.sv */
`timescale 1ns/10ps

module tb_reorder_buffer;
	import rob_pkg::*;

	localparam int clk_period = 8;
	localparam int reset_cycles = 8;
	localparam int run_cycles = 3000;
	localparam int timeout_cycles = 4000;

	typedef struct {
		logic [areg_bits-1:0]    dreg;
		logic [preg_bits-1:0]    tag;
		logic [preg_bits-1:0]    old;
		logic [rob_idx_bits-1:0] idx;
		bit                      is_br;
		bit                      done;
		bit                      mispred;
		int                      done_cyc;
		int                      disp_cyc;
		logic [xlen-1:0]         target;
	} rec_t;

	logic clock = 1'b0;
	logic arst_n;
	logic [rob_width-1:0] dispatch_en;
	logic [rob_width-1:0][areg_bits-1:0] dest_reg;
	logic [rob_width-1:0][preg_bits-1:0] new_tag;
	logic [rob_width-1:0][preg_bits-1:0] old_tag;
	logic [rob_width-1:0] cdb_valid;
	logic [rob_width-1:0][preg_bits-1:0] cdb_tag;
	logic br_valid;
	logic [preg_bits-1:0] br_tag;
	logic br_mispredict;
	logic [xlen-1:0] br_target;
	logic [rob_width-1:0] dispatch_ready;
	logic [rob_width-1:0][rob_idx_bits-1:0] rob_idx;
	logic [rob_width-1:0] retire_valid;
	logic [rob_width-1:0][areg_bits-1:0] retire_reg;
	logic [rob_width-1:0][preg_bits-1:0] retire_tag;
	logic [rob_width-1:0][preg_bits-1:0] retire_old_tag;
	logic rollback_en;
	logic [xlen-1:0] rollback_pc;

	rec_t q[$];
	int unsigned lcg_state = 73;
	int cycles = 0;
	int cyc = 0;
	int saw_full = 0;
	int saw_dual = 0;
	int saw_rollback = 0;

	reorder_buffer dut (.*);

	always #(clk_period / 2) clock = ~clock;

	always @(posedge clock) begin
		cycles++;
		if (cycles >= timeout_cycles) begin
			stop_run("timeout: the run did not finish within the cycle limit");
		end
	end

	task automatic stop_run(input string why);
		$display("%s", why);
		$display("Simulation FAILED");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
		assert (act === exp) else
			stop_run($sformatf("FAILED %s expected %0h actual %0h", name, exp, act));
	endtask

	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return (lcg_state >> 16) & 32'h7fff;
	endfunction

	// random start, then scan for an entry still waiting in the DUT
	function automatic int pick_waiting(input bit want_br);
		int n;
		int start;
		int k;
		n = q.size();
		if (n == 0) begin
			return -1;
		end
		start = lcg_next() % n;
		for (int i = 0; i < n; i++) begin
			k = (start + i) % n;
			if (!q[k].done && q[k].disp_cyc < cyc && q[k].is_br == want_br) begin
				return k;
			end
		end
		return -1;
	endfunction

	task automatic check_retire(output bit mis);
		bit exp0;
		bit exp1;
		exp0 = q.size() > 0 && q[0].done && q[0].done_cyc < cyc;
		mis = exp0 && q[0].mispred;
		exp1 = exp0 && !mis && q.size() > 1 && q[1].done && q[1].done_cyc < cyc
			&& !q[1].mispred;
		check_value("retire_valid", {exp1, exp0}, retire_valid);
		check_value("rollback_en", mis, rollback_en);
		for (int l = 0; l < 2; l++) begin
			if ((l == 0 && exp0) || (l == 1 && exp1)) begin
				check_value($sformatf("retire_reg[%0d]", l), q[l].dreg, retire_reg[l]);
				check_value($sformatf("retire_tag[%0d]", l), q[l].tag, retire_tag[l]);
				check_value($sformatf("retire_old_tag[%0d]", l), q[l].old, retire_old_tag[l]);
			end
		end
		if (mis) begin
			check_value("rollback_pc", q[0].target, rollback_pc);
		end
		if (exp1) begin
			saw_dual++;
		end
	endtask

	initial begin
		logic [rob_idx_bits-1:0] tail;
		logic [preg_bits-1:0] next_tag;
		bit mis;
		int free;
		int ndisp;
		int r;
		int k;
		int phase;
		rec_t rec;
		tail = '0;
		next_tag = '0;
		arst_n = 1'b0;
		dispatch_en = '0;
		dest_reg = '0;
		new_tag = '0;
		old_tag = '0;
		cdb_valid = '0;
		cdb_tag = '0;
		br_valid = 1'b0;
		br_tag = '0;
		br_mispredict = 1'b0;
		br_target = '0;
		repeat (reset_cycles) @(posedge clock);
		#1 arst_n = 1'b1;
		for (cyc = 1; cyc <= run_cycles; cyc++) begin
			@(posedge clock);
			#1;
			free = rob_size - q.size();
			check_value("dispatch_ready", free >= 2 ? 2'b11 : (free == 1 ? 2'b01 : 2'b00),
				dispatch_ready);
			check_value("rob_idx[0]", tail, rob_idx[0]);
			check_value("rob_idx[1]", rob_idx_bits'(tail + 1), rob_idx[1]);
			if (free == 0) begin
				saw_full++;
			end
			check_retire(mis);
			if (mis) begin
				saw_rollback++;
				tail = q[0].idx + rob_idx_bits'(1);
				q.delete();
			end
			else begin
				if (retire_valid[0]) void'(q.pop_front());
				if (retire_valid[1]) void'(q.pop_front());
			end
			// dispatch count capped by dispatch_ready
			r = lcg_next() % 8;
			ndisp = (r == 0) ? 0 : (r < 3 ? 1 : 2);
			if (mis || dispatch_ready == 2'b00) begin
				ndisp = 0;
			end
			else if (dispatch_ready == 2'b01 && ndisp > 1) begin
				ndisp = 1;
			end
			dispatch_en = '0;
			for (int l = 0; l < ndisp; l++) begin
				rec.dreg = areg_bits'(lcg_next());
				rec.tag = next_tag;
				rec.old = preg_bits'(lcg_next());
				rec.idx = tail;
				rec.is_br = (lcg_next() % 8) == 0;
				rec.done = 0;
				rec.mispred = 0;
				rec.done_cyc = 0;
				rec.disp_cyc = cyc;
				rec.target = '0;
				q.push_back(rec);
				dispatch_en[l] = 1'b1;
				dest_reg[l] = rec.dreg;
				new_tag[l] = rec.tag;
				old_tag[l] = rec.old;
				next_tag++;
				tail++;
			end
			// phase 0 stalls completions so the buffer fills, phase 1 bursts them
			phase = (cyc / 200) % 3;
			cdb_valid = '0;
			br_valid = 1'b0;
			if (phase != 0) begin
				for (int l = 0; l < 2; l++) begin
					k = (phase == 1 || lcg_next() % 2 == 0) ? pick_waiting(0) : -1;
					if (k >= 0) begin
						q[k].done = 1;
						q[k].done_cyc = cyc;
						cdb_valid[l] = 1'b1;
						cdb_tag[l] = q[k].tag;
					end
				end
				k = (lcg_next() % 3 == 0) ? pick_waiting(1) : -1;
				if (k >= 0) begin
					q[k].done = 1;
					q[k].done_cyc = cyc;
					q[k].mispred = (lcg_next() % 4) == 0;
					q[k].target = {16'(lcg_next()), 16'(lcg_next())};
					br_valid = 1'b1;
					br_tag = q[k].tag;
					br_mispredict = q[k].mispred;
					br_target = q[k].target;
				end
			end
		end
		if (saw_full == 0 || saw_dual == 0 || saw_rollback == 0) begin
			stop_run("stimulus never reached a full buffer, a dual retire or a rollback");
		end
		else begin
			$display("Simulation PASSED");
			$finish;
		end
	end

endmodule
